// ==== rtl/rate_ctrl_params.svh ====
`ifndef RATE_CTRL_PARAMS_SVH
`define RATE_CTRL_PARAMS_SVH

// width of every rate and error word
`define RATE_BIT_WIDTH 16

// pid term sum before the clamp
// three 16 bit terms cannot overflow 18 bits
`define SUM_BIT_WIDTH 18

// pid gains, signed 16 bit
`define PID_K_P 16'sd2
`define PID_K_I 16'sd1
`define PID_K_D 16'sd1

// output rate clamp limits
`define RATE_MIN (-16'sd12000)
`define RATE_MAX 16'sd12000

// roll, pitch, yaw
`define NUM_AXES 3

`endif

// ==== rtl/rate_ctrl_pkg.sv ====
`default_nettype none

`include "rate_ctrl_params.svh"

package rate_ctrl_pkg;

	// one axis worth of input for a pid run
	typedef struct packed {
		logic signed [`RATE_BIT_WIDTH-1:0] target_rate;
		logic signed [`RATE_BIT_WIDTH-1:0] actual_rate;
		logic signed [`RATE_BIT_WIDTH-1:0] angle_error;
	} axis_input_t;

	// full sample, all three axes
	typedef struct packed {
		axis_input_t roll;
		axis_input_t pitch;
		axis_input_t yaw;
	} rate_sample_t;

	// clamped rates out of the pid engines
	typedef struct packed {
		logic signed [`RATE_BIT_WIDTH-1:0] roll;
		logic signed [`RATE_BIT_WIDTH-1:0] pitch;
		logic signed [`RATE_BIT_WIDTH-1:0] yaw;
	} rate_vector_t;

endpackage

`default_nettype wire

// ==== rtl/rate_command_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module rate_command_latch
	import rate_ctrl_pkg::*;
(
	input  logic         us_clk,
	input  logic         resetn,
	input  logic         start,
	input  logic         ready,
	input  rate_sample_t sample,
	output rate_sample_t axis_cmd,
	output logic         axis_start
);

	logic accept;

	// start only counts while the core is idle
	assign accept = start & ready;

	// sample held for the whole run
	always_ff @(posedge us_clk) begin
		if (accept) begin
			axis_cmd <= sample;
		end
	end

	// engines kicked off the cycle after the accepted start
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			axis_start <= 1'b0;
		end else begin
			axis_start <= accept;
		end
	end

	// ready drops in the collector right after accept,
	// so a held start must not retrigger the engines
	axis_start_single : assert property (
		@(posedge us_clk) disable iff (!resetn)
		axis_start |=> !axis_start
	);

endmodule

`default_nettype wire

// ==== rtl/axis_pid.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rate_ctrl_params.svh"

module axis_pid
	import rate_ctrl_pkg::*;
(
	input  logic                              us_clk,
	input  logic                              resetn,
	input  logic                              axis_start,
	input  axis_input_t                       axis_in,
	output logic signed [`RATE_BIT_WIDTH-1:0] rate_out,
	output logic                              pid_done
);

	localparam int RATE_W = `RATE_BIT_WIDTH;
	localparam int SUM_W  = `SUM_BIT_WIDTH;

	localparam logic signed [RATE_W-1:0] K_P = `PID_K_P;
	localparam logic signed [RATE_W-1:0] K_I = `PID_K_I;
	localparam logic signed [RATE_W-1:0] K_D = `PID_K_D;

	localparam logic signed [RATE_W-1:0] RATE_LO = `RATE_MIN;
	localparam logic signed [RATE_W-1:0] RATE_HI = `RATE_MAX;
	localparam logic signed [SUM_W-1:0]  SUM_LO  = SUM_W'(RATE_LO);
	localparam logic signed [SUM_W-1:0]  SUM_HI  = SUM_W'(RATE_HI);

	// one-hot states
	localparam logic [5:0]
		S_WAIT     = 6'b000001,
		S_CALC1    = 6'b000010,
		S_CALC2    = 6'b000100,
		S_CALC3    = 6'b001000,
		S_CALC4    = 6'b010000,
		S_COMPLETE = 6'b100000;

	logic [5:0] state;
	logic [5:0] next_state;

	// working terms
	logic signed [RATE_W-1:0] err;
	logic signed [RATE_W-1:0] prev_err;
	logic signed [RATE_W-1:0] err_change;
	logic signed [RATE_W-1:0] p_term;
	logic signed [RATE_W-1:0] i_term;
	logic signed [RATE_W-1:0] d_term;
	logic signed [SUM_W-1:0]  sum;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_WAIT;
		end else begin
			state <= next_state;
		end
	end

	// fixed walk through the calc states, start ignored unless idle
	always_comb begin
		case (state)
			S_WAIT:     next_state = axis_start ? S_CALC1 : S_WAIT;
			S_CALC1:    next_state = S_CALC2;
			S_CALC2:    next_state = S_CALC3;
			S_CALC3:    next_state = S_CALC4;
			S_CALC4:    next_state = S_COMPLETE;
			S_COMPLETE: next_state = S_WAIT;
			default:    next_state = S_WAIT;
		endcase
	end

	// products truncate to 16 bits, the sum is widened first
	always_ff @(posedge us_clk) begin
		case (state)
			S_CALC1: begin
				err    <= axis_in.target_rate - axis_in.actual_rate;
				i_term <= K_I * axis_in.angle_error;
			end
			S_CALC2: begin
				p_term     <= K_P * err;
				err_change <= prev_err - err;
			end
			S_CALC3: begin
				d_term <= K_D * err_change;
			end
			S_CALC4: begin
				sum <= SUM_W'(p_term) + SUM_W'(i_term) + SUM_W'(d_term);
			end
			S_COMPLETE: begin
				if (sum < SUM_LO) begin
					rate_out <= RATE_LO;
				end else if (sum > SUM_HI) begin
					rate_out <= RATE_HI;
				end else begin
					rate_out <= sum[RATE_W-1:0];
				end
			end
			default: begin
			end
		endcase
	end

	// previous error carries over to the next sample
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			prev_err <= '0;
			pid_done <= 1'b0;
		end else begin
			if (state == S_CALC2) begin
				prev_err <= err;
			end
			pid_done <= (state == S_COMPLETE);
		end
	end

	pid_done_pulse : assert property (
		@(posedge us_clk) disable iff (!resetn)
		pid_done |=> !pid_done
	);

	// clamp result must be in range when it is announced
	rate_out_in_range : assert property (
		@(posedge us_clk) disable iff (!resetn)
		pid_done |-> (rate_out >= RATE_LO && rate_out <= RATE_HI)
	);

endmodule

`default_nettype wire

// ==== rtl/rate_result_collector.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rate_ctrl_params.svh"

module rate_result_collector
	import rate_ctrl_pkg::*;
(
	input  logic                              us_clk,
	input  logic                              resetn,
	input  logic                              start,
	input  logic signed [`RATE_BIT_WIDTH-1:0] roll_rate,
	input  logic signed [`RATE_BIT_WIDTH-1:0] pitch_rate,
	input  logic signed [`RATE_BIT_WIDTH-1:0] yaw_rate,
	input  logic                              roll_done,
	input  logic                              pitch_done,
	input  logic                              yaw_done,
	output logic                              ready,
	output rate_vector_t                      rates,
	output logic                              rates_valid
);

	logic [`NUM_AXES-1:0] done_flags;
	logic [`NUM_AXES-1:0] done_now;
	logic [`NUM_AXES-1:0] done_all;

	// captured per axis results
	logic signed [`RATE_BIT_WIDTH-1:0] roll_hold;
	logic signed [`RATE_BIT_WIDTH-1:0] pitch_hold;
	logic signed [`RATE_BIT_WIDTH-1:0] yaw_hold;

	rate_vector_t next_rates;

	assign done_now = {yaw_done, pitch_done, roll_done};
	assign done_all = done_flags | done_now;

	// take a rate straight from the engine if it finishes this cycle
	always_comb begin
		next_rates.roll  = roll_done  ? roll_rate  : roll_hold;
		next_rates.pitch = pitch_done ? pitch_rate : pitch_hold;
		next_rates.yaw   = yaw_done   ? yaw_rate   : yaw_hold;
	end

	always_ff @(posedge us_clk) begin
		if (roll_done) begin
			roll_hold <= roll_rate;
		end
		if (pitch_done) begin
			pitch_hold <= pitch_rate;
		end
		if (yaw_done) begin
			yaw_hold <= yaw_rate;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			done_flags  <= '0;
			ready       <= 1'b1;
			rates       <= '0;
			rates_valid <= 1'b0;
		end else begin
			rates_valid <= 1'b0;
			if (&done_all) begin
				// all axes in, publish and go idle
				rates       <= next_rates;
				rates_valid <= 1'b1;
				ready       <= 1'b1;
				done_flags  <= '0;
			end else begin
				done_flags <= done_all;
				if (start && ready) begin
					ready <= 1'b0;
				end
			end
		end
	end

	// a result only ever follows a run, never an idle cycle
	valid_after_busy : assert property (
		@(posedge us_clk) disable iff (!resetn)
		$rose(rates_valid) |-> !$past(ready)
	);

endmodule

`default_nettype wire

// ==== rtl/rate_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rate_ctrl_params.svh"

module rate_controller
	import rate_ctrl_pkg::*;
(
	input  logic         us_clk,
	input  logic         resetn,
	input  logic         start,
	input  rate_sample_t sample,
	output logic         ready,
	output rate_vector_t rates,
	output logic         rates_valid
);

	rate_sample_t axis_cmd;
	logic         axis_start;

	logic signed [`RATE_BIT_WIDTH-1:0] roll_rate;
	logic signed [`RATE_BIT_WIDTH-1:0] pitch_rate;
	logic signed [`RATE_BIT_WIDTH-1:0] yaw_rate;
	logic                              roll_done;
	logic                              pitch_done;
	logic                              yaw_done;

	rate_command_latch i_latch (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.start      (start),
		.ready      (ready),
		.sample     (sample),
		.axis_cmd   (axis_cmd),
		.axis_start (axis_start)
	);

	// one engine per axis, all started together
	axis_pid i_pid_roll (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.axis_start (axis_start),
		.axis_in    (axis_cmd.roll),
		.rate_out   (roll_rate),
		.pid_done   (roll_done)
	);

	axis_pid i_pid_pitch (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.axis_start (axis_start),
		.axis_in    (axis_cmd.pitch),
		.rate_out   (pitch_rate),
		.pid_done   (pitch_done)
	);

	axis_pid i_pid_yaw (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.axis_start (axis_start),
		.axis_in    (axis_cmd.yaw),
		.rate_out   (yaw_rate),
		.pid_done   (yaw_done)
	);

	rate_result_collector i_collector (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.roll_rate   (roll_rate),
		.pitch_rate  (pitch_rate),
		.yaw_rate    (yaw_rate),
		.roll_done   (roll_done),
		.pitch_done  (pitch_done),
		.yaw_done    (yaw_done),
		.ready       (ready),
		.rates       (rates),
		.rates_valid (rates_valid)
	);

endmodule

`default_nettype wire

// ==== testbench/rate_controller_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rate_ctrl_params.svh"

module rate_controller_tb
	import rate_ctrl_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int LATENCY      = 7;
	localparam int WAIT_LIMIT   = 20;
	localparam int SMALL_SPAN   = 1000;

	localparam int SMALL_RUNS = 40;
	localparam int LARGE_RUNS = 30;
	localparam int NOISE_RUNS = 20;
	localparam int RESET_RUNS = 10;
	// the extra one is the run cut short by reset
	localparam int NUM_RUNS   = SMALL_RUNS + LARGE_RUNS + NOISE_RUNS + RESET_RUNS + 1;
	localparam int TIMEOUT_NS = (NUM_RUNS * 12 + 100) * CLK_PERIOD;

	localparam int RATE_W  = `RATE_BIT_WIDTH;
	localparam int K_P     = int'(`PID_K_P);
	localparam int K_I     = int'(`PID_K_I);
	localparam int K_D     = int'(`PID_K_D);
	localparam int RATE_LO = int'(`RATE_MIN);
	localparam int RATE_HI = int'(`RATE_MAX);

	logic         us_clk;
	logic         resetn;
	logic         start;
	rate_sample_t sample;
	logic         ready;
	rate_vector_t rates;
	logic         rates_valid;

	integer       seed;
	int           prev_err [`NUM_AXES];
	int           sat_hits;
	rate_vector_t held_rates;

	rate_controller i_rate_controller (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.sample      (sample),
		.ready       (ready),
		.rates       (rates),
		.rates_valid (rates_valid)
	);

	initial begin
		us_clk = 1'b0;
		forever #(CLK_PERIOD / 2) us_clk = ~us_clk;
	end

	task automatic stop_on_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout at %0t, the test sequence did not finish in time", $time);
		stop_on_failure();
	end

	task automatic check_rates(input rate_vector_t expected, input rate_vector_t actual);
		if (actual !== expected) begin
			$display("FAIL time %0t rates expected %0d/%0d/%0d actual %0d/%0d/%0d",
				$time, expected.roll, expected.pitch, expected.yaw,
				actual.roll, actual.pitch, actual.yaw);
			stop_on_failure();
		end
	endtask

	task automatic check_ready(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL time %0t ready expected %b actual %b", $time, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_valid(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL time %0t rates_valid expected %b actual %b",
				$time, expected, actual);
			stop_on_failure();
		end
	endtask

	// span 0 means the full signed word
	function automatic logic signed [RATE_W-1:0] random_word(input int span);
		int r;
		r = $random(seed);
		if (span > 0) begin
			r = r % span;
		end
		return RATE_W'(r);
	endfunction

	function automatic rate_sample_t random_sample(input int span);
		rate_sample_t s;
		s.roll.target_rate  = random_word(span);
		s.roll.actual_rate  = random_word(span);
		s.roll.angle_error  = random_word(span);
		s.pitch.target_rate = random_word(span);
		s.pitch.actual_rate = random_word(span);
		s.pitch.angle_error = random_word(span);
		s.yaw.target_rate   = random_word(span);
		s.yaw.actual_rate   = random_word(span);
		s.yaw.angle_error   = random_word(span);
		return s;
	endfunction

	// two's complement wrap of a product or difference to one word
	function automatic int wrap_word(input int v);
		logic signed [RATE_W-1:0] w;
		w = RATE_W'(v);
		return int'(w);
	endfunction

	// reference pid step for one axis, updates that axis's previous error
	function automatic logic signed [RATE_W-1:0] axis_rate(input axis_input_t ax, input int idx);
		int err;
		int p_val;
		int i_val;
		int d_val;
		int sum;
		err   = wrap_word(int'(ax.target_rate) - int'(ax.actual_rate));
		i_val = wrap_word(K_I * int'(ax.angle_error));
		p_val = wrap_word(K_P * err);
		d_val = wrap_word(K_D * wrap_word(prev_err[idx] - err));
		sum   = p_val + i_val + d_val;
		if (sum < RATE_LO) begin
			sum = RATE_LO;
			sat_hits++;
		end else if (sum > RATE_HI) begin
			sum = RATE_HI;
			sat_hits++;
		end
		prev_err[idx] = err;
		return RATE_W'(sum);
	endfunction

	function automatic rate_vector_t model_run(input rate_sample_t s);
		rate_vector_t v;
		v.roll  = axis_rate(s.roll, 0);
		v.pitch = axis_rate(s.pitch, 1);
		v.yaw   = axis_rate(s.yaw, 2);
		return v;
	endfunction

	task automatic clear_model();
		for (int a = 0; a < `NUM_AXES; a++) begin
			prev_err[a] = 0;
		end
		held_rates = '0;
	endtask

	task automatic check_idle();
		@(negedge us_clk);
		check_ready(1'b1, ready);
		check_valid(1'b0, rates_valid);
		check_rates(held_rates, rates);
	endtask

	// one accepted start, optionally with ignored starts and sample noise during the run
	task automatic do_run(input int span, input bit noise);
		rate_sample_t s;
		rate_vector_t expected;
		int           cycles;
		bit           done;
		s = random_sample(span);
		check_idle();
		@(posedge us_clk);
		start  <= 1'b1;
		sample <= s;
		expected = model_run(s);
		@(posedge us_clk);
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			if (noise && cycles < LATENCY) begin
				start  <= 1'($random(seed));
				sample <= random_sample(0);
			end else begin
				start <= 1'b0;
			end
			@(negedge us_clk);
			if (rates_valid) begin
				done = 1'b1;
			end else begin
				check_ready(1'b0, ready);
				check_rates(held_rates, rates);
				if (cycles == WAIT_LIMIT) begin
					$display("no rates_valid within %0d cycles of the start, time %0t",
						WAIT_LIMIT, $time);
					stop_on_failure();
				end
				cycles++;
				@(posedge us_clk);
			end
		end
		if (cycles != LATENCY) begin
			$display("rates_valid came %0d cycles after the start instead of %0d, time %0t",
				cycles, LATENCY, $time);
			stop_on_failure();
		end
		check_ready(1'b1, ready);
		check_rates(expected, rates);
		held_rates = expected;
	endtask

	// reset lands while the engines are busy
	task automatic reset_mid_run();
		rate_sample_t s;
		s = random_sample(SMALL_SPAN);
		check_idle();
		@(posedge us_clk);
		start  <= 1'b1;
		sample <= s;
		@(posedge us_clk);
		start <= 1'b0;
		repeat (3) @(posedge us_clk);
		resetn <= 1'b0;
		repeat (RESET_CYCLES) @(posedge us_clk);
		resetn <= 1'b1;
		clear_model();
		check_idle();
	endtask

	initial begin
		seed     = 98691;
		resetn   = 1'b0;
		start    = 1'b0;
		sample   = '0;
		sat_hits = 0;
		clear_model();

		repeat (RESET_CYCLES) @(posedge us_clk);
		resetn <= 1'b1;
		check_idle();

		for (int n = 0; n < SMALL_RUNS; n++) begin
			do_run(SMALL_SPAN, 1'b0);
		end

		for (int n = 0; n < LARGE_RUNS; n++) begin
			do_run(0, 1'b0);
		end
		if (sat_hits == 0) begin
			$display("large random inputs never drove a sum past a clamp limit");
			stop_on_failure();
		end

		for (int n = 0; n < NOISE_RUNS; n++) begin
			do_run(SMALL_SPAN, 1'b1);
		end

		reset_mid_run();
		for (int n = 0; n < RESET_RUNS; n++) begin
			do_run(SMALL_SPAN, 1'b0);
		end

		check_idle();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rate_controller.f ====
+incdir+rtl
rtl/rate_ctrl_pkg.sv
rtl/rate_command_latch.sv
rtl/axis_pid.sv
rtl/rate_result_collector.sv
rtl/rate_controller.sv
testbench/rate_controller_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rate controller testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f rate_controller.f \
	--top-module rate_controller_tb \
	-o Vrate_controller_tb

# the simulator exits non-zero on a failed check, the log is searched below
./obj_dir/Vrate_controller_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
	exit 0
fi
exit 1
